//--- hw/cpu_pkg.sv
package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int NUM_WORDS  = 32;
    localparam int IMEM_WORDS = 64;
    localparam int IMEM_AW    = $clog2(IMEM_WORDS);   // fetch word index width

    typedef logic [XLEN-1:0] word_t;
    typedef logic [7:0]      byte_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [1:0]      lane_t;
    typedef logic [2:0]      pattern_t;

    // loader and signature codes on the byte input
    localparam byte_t LOAD_START  = 8'hFE;
    localparam byte_t LOAD_RUN    = 8'hFF;
    localparam byte_t SIG_TRIGGER = 8'hAA;

    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    localparam byte_t SIG_PATTERN_0 = 8'h0D;
    localparam byte_t SIG_PATTERN_1 = 8'h36;
    localparam byte_t SIG_PATTERN_2 = 8'h9A;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR} alu_op_t;

    typedef enum logic [2:0] {
        CORE_IDLE, CORE_FETCH, CORE_DECODE, CORE_EXECUTE, CORE_MEMORY, CORE_WRITEBACK
    } core_state_t;

    typedef enum logic [1:0] {LD_WAIT_START, LD_LOADING, LD_RUNNING} loader_state_t;

    typedef struct packed {
        logic               we;
        logic [IMEM_AW-1:0] idx;
        word_t              data;
    } imem_wr_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    imm_sel;     // second operand is the immediate
        logic    store_imm;   // S-type immediate instead of I-type
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
    } exec_ctrl_t;

endpackage

//--- hw/instr_loader.sv
module instr_loader import cpu_pkg::*; (
    input  logic     clk_i,
    input  logic     reset,
    input  byte_t    instr_i,
    output imem_wr_t imem_wr_o,
    output logic     running_o,
    output logic     loading_o
);

    loader_state_t      state;
    logic [1:0]         byte_cnt;
    logic [23:0]        shift_q;     // lower three bytes of the word in flight
    logic [IMEM_AW-1:0] word_idx;

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            state    <= LD_WAIT_START;
            byte_cnt <= 2'd0;
            word_idx <= '0;
        end else begin
            case (state)
                LD_WAIT_START: begin
                    if (instr_i == LOAD_START) begin
                        state    <= LD_LOADING;
                        byte_cnt <= 2'd0;
                        word_idx <= '0;
                    end
                end
                LD_LOADING: begin
                    if (byte_cnt == 2'd0 && instr_i == LOAD_RUN) begin
                        state <= LD_RUNNING;        // only at a word boundary
                    end else begin
                        byte_cnt <= byte_cnt + 2'd1;
                        if (byte_cnt == 2'd3) begin
                            word_idx <= word_idx + 1'b1;
                        end
                    end
                end
                default: state <= LD_RUNNING;       // held until reset
            endcase
        end
    end

    // lsb first, so each new byte enters at the top
    always_ff @(posedge clk_i) begin
        shift_q <= {instr_i, shift_q[23:8]};
    end

    assign imem_wr_o.we   = (state == LD_LOADING) && (byte_cnt == 2'd3);
    assign imem_wr_o.idx  = word_idx;
    assign imem_wr_o.data = {instr_i, shift_q};

    assign running_o = (state == LD_RUNNING);
    assign loading_o = (state == LD_LOADING);

endmodule

//--- hw/instr_mem.sv
module instr_mem import cpu_pkg::*; (
    input  logic               clk_i,
    input  imem_wr_t           imem_wr_i,
    input  logic [IMEM_AW-1:0] fetch_idx_i,
    output word_t              instr_o
);

    word_t mem [IMEM_WORDS];

    // loader write port
    always_ff @(posedge clk_i) begin
        if (imem_wr_i.we) begin
            mem[imem_wr_i.idx] <= imem_wr_i.data;
        end
    end

    // fetch data arrives one cycle after the index
    always_ff @(posedge clk_i) begin
        instr_o <= mem[fetch_idx_i];
    end

endmodule

//--- hw/core_ctrl.sv
module core_ctrl import cpu_pkg::*; (
    input  logic               clk_i,
    input  logic               reset,
    input  logic               running_i,
    input  word_t              instr_i,
    input  logic               alu_eq_i,
    output logic [IMEM_AW-1:0] fetch_idx_o,
    output word_t              instr_o,
    output exec_ctrl_t         ctrl_o,
    output reg_addr_t          rs1_o,
    output reg_addr_t          rs2_o,
    output reg_addr_t          rd_o,
    output logic               reg_we_o,
    output logic               wb_sel_mem_o,
    output logic               mem_rd_o,
    output logic               mem_wr_o
);

    core_state_t state;
    word_t       pc;
    word_t       ir;
    word_t       br_off;
    word_t       next_pc;
    logic        is_beq;
    logic        is_mem;

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            state <= CORE_IDLE;
            pc    <= '0;
        end else begin
            case (state)
                CORE_IDLE:    if (running_i) state <= CORE_FETCH;
                CORE_FETCH:   state <= CORE_DECODE;
                CORE_DECODE:  state <= CORE_EXECUTE;
                CORE_EXECUTE: begin
                    pc    <= next_pc;
                    state <= is_mem ? CORE_MEMORY : CORE_WRITEBACK;
                end
                CORE_MEMORY:  state <= ctrl_o.mem_write ? CORE_FETCH : CORE_WRITEBACK;
                default:      state <= CORE_FETCH;
            endcase
        end
    end

    // instruction word lands from imem during decode
    always_ff @(posedge clk_i) begin
        if (state == CORE_DECODE) begin
            ir <= instr_i;
        end
    end

    always_comb begin
        ctrl_o = '{alu_op: ALU_ADD, default: 1'b0};   // unknown opcode is a no-op
        case (ir[6:0])
            OP_IMM, OP_REG: begin
                ctrl_o.imm_sel   = (ir[6:0] == OP_IMM);
                ctrl_o.reg_write = 1'b1;
                case (ir[14:12])
                    3'b000: begin
                        if (ir[6:0] == OP_REG && ir[30]) ctrl_o.alu_op = ALU_SUB;
                    end
                    3'b111:  ctrl_o.alu_op = ALU_AND;
                    3'b110:  ctrl_o.alu_op = ALU_OR;
                    default: ctrl_o.reg_write = 1'b0;
                endcase
            end
            OP_LOAD: begin
                ctrl_o.imm_sel   = 1'b1;
                ctrl_o.reg_write = 1'b1;
                ctrl_o.mem_read  = 1'b1;
            end
            OP_STORE: begin
                ctrl_o.imm_sel   = 1'b1;
                ctrl_o.store_imm = 1'b1;
                ctrl_o.mem_write = 1'b1;
            end
            default: ;
        endcase
    end

    assign is_beq  = (ir[6:0] == OP_BRANCH) && (ir[14:12] == 3'b000);
    assign is_mem  = ctrl_o.mem_read | ctrl_o.mem_write;
    assign br_off  = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};  // B-type
    assign next_pc = (is_beq && alu_eq_i) ? pc + br_off : pc + 32'd4;

    assign fetch_idx_o  = pc[IMEM_AW+1:2];
    assign instr_o      = ir;
    assign rs1_o        = ir[19:15];
    assign rs2_o        = ir[24:20];
    assign rd_o         = ir[11:7];
    assign reg_we_o     = (state == CORE_WRITEBACK) && ctrl_o.reg_write;
    assign wb_sel_mem_o = ctrl_o.mem_read;
    // read data must stay valid through writeback
    assign mem_rd_o     = ctrl_o.mem_read &&
                          (state == CORE_MEMORY || state == CORE_WRITEBACK);
    assign mem_wr_o     = (state == CORE_MEMORY) && ctrl_o.mem_write;

endmodule

//--- hw/alu.sv
module alu import cpu_pkg::*; (
    input  word_t      instr_i,
    input  exec_ctrl_t ctrl_i,
    input  word_t      rs1_data_i,
    input  word_t      rs2_data_i,
    output word_t      result_o,
    output logic       eq_o
);

    word_t imm_i;
    word_t imm_s;
    word_t imm;
    word_t op_b;

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};   // sw offset
    assign imm   = ctrl_i.store_imm ? imm_s : imm_i;
    assign op_b  = ctrl_i.imm_sel ? imm : rs2_data_i;

    always_comb begin
        case (ctrl_i.alu_op)
            ALU_ADD: result_o = rs1_data_i + op_b;
            ALU_SUB: result_o = rs1_data_i - op_b;
            ALU_AND: result_o = rs1_data_i & op_b;
            default: result_o = rs1_data_i | op_b;
        endcase
    end

    // branch compare always on the two registers
    assign eq_o = (rs1_data_i == rs2_data_i);

endmodule

//--- hw/reg_file.sv
module reg_file import cpu_pkg::*; (
    input  logic      clk_i,
    input  logic      reset,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    input  reg_addr_t rd_i,
    input  reg_addr_t dbg_addr_i,
    input  logic      we_i,
    input  word_t     wdata_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o,
    output word_t     dbg_data_o
);

    word_t regs [NUM_WORDS];

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_WORDS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin   // x0 stays zero
            regs[rd_i] <= wdata_i;
        end
    end

    assign rs1_data_o = regs[rs1_i];
    assign rs2_data_o = regs[rs2_i];
    assign dbg_data_o = regs[dbg_addr_i];      // operator readout

endmodule

//--- hw/data_mem.sv
module data_mem import cpu_pkg::*; (
    input  logic      clk_i,
    input  logic      reset,
    input  word_t     addr_i,
    input  word_t     wdata_i,
    input  logic      rd_i,
    input  logic      wr_i,
    input  reg_addr_t dbg_addr_i,
    output word_t     rdata_o,
    output word_t     dbg_data_o
);

    word_t     mem [NUM_WORDS];
    reg_addr_t word_idx;

    assign word_idx = addr_i[6:2];             // byte address to word index

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_i) begin
            mem[word_idx] <= wdata_i;
        end
    end

    assign rdata_o    = rd_i ? mem[word_idx] : '0;
    assign dbg_data_o = mem[dbg_addr_i];

endmodule

//--- hw/signature_player.sv
module signature_player import cpu_pkg::*; (
    input  logic     clk_i,
    input  logic     reset,
    input  byte_t    instr_i,
    input  logic     loading_i,
    output pattern_t sig_o
);

    logic       armed;       // trigger seen, playback starts next cycle
    logic       play;
    logic [2:0] bit_cnt;
    logic [2:0] bit_sel;

    assign bit_sel = 3'd7 - bit_cnt;           // msb first

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            armed   <= 1'b0;
            play    <= 1'b0;
            bit_cnt <= 3'd0;
            sig_o   <= '0;
        end else begin
            armed <= (instr_i == SIG_TRIGGER) && !loading_i && !armed && !play;
            if (armed) begin
                play    <= 1'b1;
                bit_cnt <= 3'd0;
            end else if (play) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) play <= 1'b0;
            end
            if (play) begin
                sig_o <= {SIG_PATTERN_2[bit_sel], SIG_PATTERN_1[bit_sel], SIG_PATTERN_0[bit_sel]};
            end else begin
                sig_o <= '0;
            end
        end
    end

endmodule

//--- hw/cpu_top.sv
module cpu_top import cpu_pkg::*; (
    input  logic      clk_i,
    input  logic      reset,
    input  byte_t     instr_i,
    input  logic      data_or_reg_i,
    input  reg_addr_t address_i,
    input  lane_t     vout_addr_i,
    output byte_t     value_o,
    output pattern_t  easter_egg_o
);

    imem_wr_t           imem_wr;
    logic               running;
    logic               loading;
    logic [IMEM_AW-1:0] fetch_idx;
    word_t              fetch_word;
    word_t              cur_instr;
    exec_ctrl_t         ctrl;
    reg_addr_t          rs1, rs2, rd;
    logic               reg_we, wb_sel_mem, mem_rd, mem_wr;
    word_t              rs1_data, rs2_data, alu_result, mem_rdata, wb_data;
    logic               alu_eq;
    word_t              reg_dbg, mem_dbg, readout_word;

    instr_loader u_loader (
        .clk_i, .reset, .instr_i,
        .imem_wr_o (imem_wr),
        .running_o (running),
        .loading_o (loading)
    );

    instr_mem u_imem (
        .clk_i,
        .imem_wr_i   (imem_wr),
        .fetch_idx_i (fetch_idx),
        .instr_o     (fetch_word)
    );

    core_ctrl u_ctrl (
        .clk_i, .reset,
        .running_i    (running),
        .instr_i      (fetch_word),
        .alu_eq_i     (alu_eq),
        .fetch_idx_o  (fetch_idx),
        .instr_o      (cur_instr),
        .ctrl_o       (ctrl),
        .rs1_o        (rs1),
        .rs2_o        (rs2),
        .rd_o         (rd),
        .reg_we_o     (reg_we),
        .wb_sel_mem_o (wb_sel_mem),
        .mem_rd_o     (mem_rd),
        .mem_wr_o     (mem_wr)
    );

    alu u_alu (
        .instr_i (cur_instr), .ctrl_i (ctrl),
        .rs1_data_i (rs1_data), .rs2_data_i (rs2_data),
        .result_o (alu_result), .eq_o (alu_eq)
    );

    assign wb_data = wb_sel_mem ? mem_rdata : alu_result;   // lw vs alu result

    reg_file u_regs (
        .clk_i, .reset,
        .rs1_i (rs1), .rs2_i (rs2), .rd_i (rd), .dbg_addr_i (address_i),
        .we_i (reg_we), .wdata_i (wb_data),
        .rs1_data_o (rs1_data), .rs2_data_o (rs2_data), .dbg_data_o (reg_dbg)
    );

    data_mem u_dmem (
        .clk_i, .reset,
        .addr_i (alu_result), .wdata_i (rs2_data),
        .rd_i (mem_rd), .wr_i (mem_wr), .dbg_addr_i (address_i),
        .rdata_o (mem_rdata), .dbg_data_o (mem_dbg)
    );

    signature_player u_sig (
        .clk_i, .reset, .instr_i,
        .loading_i (loading),
        .sig_o     (easter_egg_o)
    );

    // byte-lane readout
    assign readout_word = data_or_reg_i ? reg_dbg : mem_dbg;
    assign value_o      = readout_word[{vout_addr_i, 3'b000} +: 8];

endmodule

//--- tb/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// expected word of one register or data word
typedef struct packed {
    logic        is_reg;
    logic [4:0]  addr;
    logic [31:0] value;
} expect_t;

localparam int          A_VAL = 25;
localparam int          B_VAL = 10;
localparam logic [31:0] K_VAL = 32'h5A3;
localparam logic [31:0] NEG_K = 32'd0 - K_VAL;        // x8 = x0 - x7

localparam logic [31:0] PROGRAM [16] = '{
    32'h01900093,   // 0x00 addi x1, x0, 25
    32'h00A00113,   // 0x04 addi x2, x0, 10
    32'h002081B3,   // 0x08 add  x3, x1, x2
    32'h40208233,   // 0x0c sub  x4, x1, x2
    32'h0020F2B3,   // 0x10 and  x5, x1, x2
    32'h0020E333,   // 0x14 or   x6, x1, x2
    32'h5A300393,   // 0x18 addi x7, x0, 0x5a3
    32'h40700433,   // 0x1c sub  x8, x0, x7
    32'h00802423,   // 0x20 sw   x8, 8(x0)
    32'h00802483,   // 0x24 lw   x9, 8(x0)
    32'h00108463,   // 0x28 beq  x1, x1, +8
    32'h06300513,   // 0x2c addi x10, x0, 99 (skipped)
    32'h04D00593,   // 0x30 addi x11, x0, 77
    32'h00500013,   // 0x34 addi x0, x0, 5
    32'h00100613,   // 0x38 addi x12, x0, 1
    32'h00000063    // 0x3c beq  x0, x0, 0 (spin here)
};

localparam expect_t EXPECT_TABLE [14] = '{
    '{1'b1, 5'd1,  32'(A_VAL)},
    '{1'b1, 5'd2,  32'(B_VAL)},
    '{1'b1, 5'd3,  32'(A_VAL + B_VAL)},
    '{1'b1, 5'd4,  32'(A_VAL - B_VAL)},
    '{1'b1, 5'd5,  32'(A_VAL & B_VAL)},
    '{1'b1, 5'd6,  32'(A_VAL | B_VAL)},
    '{1'b1, 5'd7,  K_VAL},
    '{1'b1, 5'd8,  NEG_K},
    '{1'b0, 5'd2,  NEG_K},          // data word 2 holds byte address 8
    '{1'b1, 5'd9,  NEG_K},
    '{1'b1, 5'd11, 32'd77},
    '{1'b1, 5'd12, 32'd1},
    '{1'b1, 5'd10, 32'd0},          // skipped by the branch
    '{1'b1, 5'd0,  32'd0}
};

`endif

//--- tb/cpu_tb.sv
module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          POLL_LIMIT   = 100;     // word reads before giving up
    localparam logic [31:0] SEED         = 32'h3772e1d2;
    localparam logic [7:0]  START_CODE   = 8'hFE;
    localparam logic [7:0]  RUN_CODE     = 8'hFF;
    localparam logic [7:0]  TRIGGER_CODE = 8'hAA;
    localparam logic [7:0]  PAT0         = 8'h0D;
    localparam logic [7:0]  PAT1         = 8'h36;
    localparam logic [7:0]  PAT2         = 8'h9A;

    `include "tb_program.svh"

    logic        clk_i;
    logic        reset;
    logic [7:0]  instr_i;
    logic        data_or_reg_i;
    logic [4:0]  address_i;
    logic [1:0]  vout_addr_i;
    logic [7:0]  value_o;
    logic [2:0]  easter_egg_o;

    int          checks;
    int          errors;
    logic [31:0] rng_state;

    cpu_top UUT (
        .clk_i, .reset, .instr_i, .data_or_reg_i, .address_i,
        .vout_addr_i, .value_o, .easter_egg_o
    );

    always #20 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic send_byte(input logic [7:0] b);
        @(posedge clk_i);
        #2;
        instr_i = b;
    endtask

    task automatic read_lane(input logic is_reg, input logic [4:0] addr,
                             input logic [1:0] lane, output logic [7:0] b);
        @(posedge clk_i);
        #2;
        data_or_reg_i = is_reg;
        address_i     = addr;
        vout_addr_i   = lane;
        @(negedge clk_i);                       // readout settled mid-cycle
        b = value_o;
    endtask

    task automatic read_word(input logic is_reg, input logic [4:0] addr,
                             output logic [31:0] w);
        logic [7:0] b;
        for (int lane = 0; lane < 4; lane++) begin
            read_lane(is_reg, addr, 2'(lane), b);
            w[8*lane +: 8] = b;
        end
    endtask

    task automatic check_reset();
        logic [31:0] got;
        checks++;
        assert (easter_egg_o == 3'b000) else begin
            errors++;
            $display("error at %0t ns: easter_egg_o expected 000, got %b", $time, easter_egg_o);
        end
        for (int r = 0; r < 32; r++) begin
            read_word(1'b1, 5'(r), got);
            checks++;
            assert (got === 32'd0) else begin
                errors++;
                $display("error at %0t ns: register %0d after reset expected 0, got %h",
                         $time, r, got);
            end
        end
    endtask

    task automatic load_program();
        send_byte(START_CODE);
        foreach (PROGRAM[w]) begin
            for (int b = 0; b < 4; b++) begin
                send_byte(PROGRAM[w][8*b +: 8]);    // lsb first
            end
        end
        send_byte(RUN_CODE);
        send_byte(8'h00);
    endtask

    task automatic poll_word(input expect_t e);
        logic [31:0] got;
        int          polls;
        string       kind;
        kind  = e.is_reg ? "register" : "data word";
        polls = 0;
        read_word(e.is_reg, e.addr, got);
        while (got !== e.value && polls < POLL_LIMIT) begin
            polls++;
            read_word(e.is_reg, e.addr, got);
        end
        checks++;
        assert (got === e.value) else begin
            errors++;
            $display("error at %0t ns: %s %0d expected %h, got %h",
                     $time, kind, e.addr, e.value, got);
            $display("timeout waiting for %s %0d", kind, e.addr);
        end
    endtask

    task automatic check_lanes(input logic is_reg, input logic [4:0] addr,
                               input logic [31:0] exp_word);
        int         order [4];
        int         j;
        int         tmp;
        logic [7:0] got;
        order = '{0, 1, 2, 3};
        for (int i = 3; i > 0; i--) begin          // shuffle the lane order
            rng_state = xorshift32(rng_state);
            j         = int'(rng_state % (i + 1));
            tmp       = order[i];
            order[i]  = order[j];
            order[j]  = tmp;
        end
        foreach (order[k]) begin
            read_lane(is_reg, addr, 2'(order[k]), got);
            checks++;
            assert (got === exp_word[8*order[k] +: 8]) else begin
                errors++;
                $display("error at %0t ns: lane %0d of word %0d expected %h, got %h",
                         $time, order[k], addr, exp_word[8*order[k] +: 8], got);
            end
        end
    endtask

    task automatic play_signature();
        logic [2:0] exp_sig;
        send_byte(TRIGGER_CODE);                // sampled at the next edge
        send_byte(8'h00);
        @(posedge clk_i);
        @(negedge clk_i);
        checks++;
        assert (easter_egg_o == 3'b000) else begin
            errors++;
            $display("error at %0t ns: signature early, got %b", $time, easter_egg_o);
        end
        for (int i = 7; i >= 0; i--) begin
            exp_sig = {PAT2[i], PAT1[i], PAT0[i]};
            @(posedge clk_i);
            @(negedge clk_i);
            checks++;
            assert (easter_egg_o === exp_sig) else begin
                errors++;
                $display("error at %0t ns: signature bit %0d expected %b, got %b",
                         $time, i, exp_sig, easter_egg_o);
            end
        end
        @(posedge clk_i);
        @(negedge clk_i);
        checks++;
        assert (easter_egg_o == 3'b000) else begin
            errors++;
            $display("error at %0t ns: signature not cleared, got %b", $time, easter_egg_o);
        end
    endtask

    initial begin
        clk_i         = 1'b0;
        reset         = 1'b1;
        instr_i       = 8'h00;
        data_or_reg_i = 1'b1;
        address_i     = 5'd0;
        vout_addr_i   = 2'd0;
        checks        = 0;
        errors        = 0;
        rng_state     = SEED;
        repeat (10) @(posedge clk_i);
        #2;
        reset = 1'b0;

        check_reset();
        load_program();
        foreach (EXPECT_TABLE[i]) begin
            poll_word(EXPECT_TABLE[i]);
        end
        check_lanes(1'b1, 5'd8, NEG_K);
        check_lanes(1'b0, 5'd2, NEG_K);
        play_signature();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+tb
hw/cpu_pkg.sv
hw/instr_loader.sv
hw/instr_mem.sv
hw/core_ctrl.sv
hw/alu.sv
hw/reg_file.sv
hw/data_mem.sv
hw/signature_player.sv
hw/cpu_top.sv
tb/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu

sources:
  - hw/cpu_pkg.sv
  - hw/instr_loader.sv
  - hw/instr_mem.sv
  - hw/core_ctrl.sv
  - hw/alu.sv
  - hw/reg_file.sv
  - hw/data_mem.sv
  - hw/signature_player.sv
  - hw/cpu_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/cpu_tb.sv
